// File: testbench/program_trace.txt
# p <instruction word> | d <byte address> <data word> | s <test> <byte address> <data>
# store records are listed in program order, a test ends at its last record
d 00000040 11111111
d 00000044 22222222
p 00500093
p 00C00113
p 123451B7
p 00001217
p 002082B3
p 40110333
p 0020C3B3
p 00411413
p FF000493
p 4024D513
p 01C4D593
p 0020E633
p 0020F6B3
p 10302023
p 10402223
p 10502423
p 10602623
p 10702823
p 10802A23
p 10A02C23
p 10B02E23
p 12C02023
p 12D02223
p 00300713
p 00E70733
p 00170713
p 12E02423
p 04002783
p 04402803
p 010788B3
p 13102623
p 00208463
p 00100913
p 13202823
p 00209663
p 12102A23
p 12202A23
p 0014C663
p 12102A23
p 12202A23
p 0090F463
p 00200993
p 0014F463
p 06300993
p 13302C23
p 0014AA33
p 0014BAB3
p 0060AB13
p 00708013
p 13402E23
p 15502023
p 15602223
p 14002423
p C0DE1BB7
p 1F702E23
p 00000063
s arith 00000100 12345000
s arith 00000104 0000100C
s arith 00000108 00000011
s arith 0000010C 00000007
s arith 00000110 00000009
s arith 00000114 000000C0
s arith 00000118 FFFFFFFC
s arith 0000011C 0000000F
s arith 00000120 0000000D
s arith 00000124 00000004
s dependent 00000128 00000007
s load_use 0000012C 33333333
s branch 00000130 00000001
s branch 00000138 00000002
s compare 0000013C 00000001
s compare 00000140 00000000
s compare 00000144 00000001
s compare 00000148 00000000
s marker 000001FC C0DE1000

// File: cpu_top.f
hw/rv32i_pkg.sv
hw/hazard_if.sv
hw/pipe_register.sv
hw/regfile.sv
hw/alu.sv
hw/control_unit.sv
hw/datapath.sv
hw/cpu_top.sv
testbench/cpu_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_top_tb
FILELIST  ?= cpu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/cpu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top_tb;

  localparam int clk_half = 2;
  localparam int reset_cycles = 4;
  localparam string trace_path = "testbench/program_trace.txt";

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_address;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_address;
  logic [31:0] dmem_wdata;
  logic        dmem_read;
  logic        dmem_write;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];

  // expected stores in program order
  string       exp_name[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];

  int  exp_idx;
  int  prog_words;
  int  errors;
  int  tests_passed;
  int  tests_failed;
  bit  test_bad;
  bit  loaded;
  bit  finished;

  cpu_top DUT (
    .clk(clk), .rst_n(rst_n),
    .imem_address(imem_address), .imem_rdata(imem_rdata),
    .dmem_address(dmem_address), .dmem_wdata(dmem_wdata),
    .dmem_read(dmem_read), .dmem_write(dmem_write),
    .dmem_rdata(dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  //**************************************************************************
  // trace loading
  //**************************************************************************

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    string       body;
    string       name;
    logic [31:0] a;
    logic [31:0] d;
    // unused words get a harmless addi x0 whose immediate is the index
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[11:0], 20'h00013};
      dmem[i] = 32'hd000_0000 ^ (i * 32'h0101_0101);
    end
    prog_words = 0;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("cannot open trace file %s", trace_path);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 2) continue;
      body = line.substr(2, line.len() - 1);
      case (line.getc(0))
        "p": begin
          n = $sscanf(body, "%h", d);
          imem[prog_words] = d;
          prog_words++;
        end
        "d": begin
          n = $sscanf(body, "%h %h", a, d);
          dmem[a[9:2]] = d;
        end
        "s": begin
          n = $sscanf(body, "%s %h %h", name, a, d);
          exp_name.push_back(name);
          exp_addr.push_back(a);
          exp_data.push_back(d);
        end
        default: ;
      endcase
    end
    $fclose(fd);
  endtask

  //**************************************************************************
  // memory model
  //**************************************************************************

  // read data follows the registered addresses
  always @(posedge clk) begin
    #1;
    imem_rdata = imem[imem_address[9:2]];
    // data memory answers only while the read strobe is up
    dmem_rdata = dmem_read ? dmem[dmem_address[9:2]] : '0;
  end

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    string name;
    if (exp_idx >= exp_name.size()) begin
      $display("unexpected store of %h to address %h after the last expected store",
               data, addr);
      errors++;
      return;
    end
    name = exp_name[exp_idx];
    if (addr != exp_addr[exp_idx]) begin
      $display("FAILED %s address: expected %h, actual %h", name, exp_addr[exp_idx], addr);
      errors++;
      test_bad = 1'b1;
    end
    if (data != exp_data[exp_idx]) begin
      $display("FAILED %s data: expected %h, actual %h", name, exp_data[exp_idx], data);
      errors++;
      test_bad = 1'b1;
    end
    exp_idx++;
    // a test ends with its last store record
    if (exp_idx == exp_name.size() || exp_name[exp_idx] != name) begin
      if (test_bad) begin
        $display("test %s: failed", name);
        tests_failed++;
      end else begin
        $display("test %s: ok", name);
        tests_passed++;
      end
      test_bad = 1'b0;
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n && dmem_read && dmem_write) begin
      $display("read and write strobes both high at address %h", dmem_address);
      errors++;
    end
    if (rst_n && dmem_write) begin
      check_store(dmem_address, dmem_wdata);
      dmem[dmem_address[9:2]] = dmem_wdata;
    end
  end

  //**************************************************************************
  // watchdog
  //**************************************************************************

  initial begin
    int limit;
    wait (loaded);
    limit = 16 * prog_words + 100;
    repeat (limit) @(posedge clk);
    if (exp_idx < exp_name.size()) begin
      $display("program did not finish within %0d cycles, %0d of %0d stores seen",
               limit, exp_idx, exp_name.size());
      $display("Testbench failed");
      $finish;
    end else begin
      // the final branch has spun for the rest of the window
      finished = 1'b1;
    end
  end

  //**************************************************************************
  // main sequence
  //**************************************************************************

  initial begin
    rst_n = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    exp_idx = 0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_bad = 1'b0;
    finished = 1'b0;
    load_trace();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
    // stores are checked as they happen until the watchdog window closes
    wait (finished);
    $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && exp_name.size() > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import rv32i_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] imem_address,
  input  logic [31:0] imem_rdata,
  output logic [31:0] dmem_address,
  output logic [31:0] dmem_wdata,
  output logic        dmem_read,
  output logic        dmem_write,
  input  logic [31:0] dmem_rdata
);

  rv32i_opcode opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  idex_rd;
  logic        idex_we;
  logic [4:0]  exmem_rd;
  logic        exmem_we;
  logic [4:0]  memwb_rd;
  logic        memwb_we;
  logic        branch_taken;
  ctrl_word    idex_ctrl_word;

  hazard_if hz ();

  control_unit control_unit (
    .clk(clk), .rst_n(rst_n),
    .opcode(opcode), .funct3(funct3), .funct7(funct7), .rs1(rs1), .rs2(rs2),
    .idex_rd(idex_rd), .idex_we(idex_we),
    .exmem_rd(exmem_rd), .exmem_we(exmem_we),
    .memwb_rd(memwb_rd), .memwb_we(memwb_we),
    .branch_taken(branch_taken),
    .idex_ctrl_word(idex_ctrl_word),
    .hz(hz.ctrl)
  );

  datapath datapath (
    .clk(clk), .rst_n(rst_n),
    .hz(hz.dp),
    .idex_ctrl_word(idex_ctrl_word),
    .opcode(opcode), .funct3(funct3), .funct7(funct7), .rs1(rs1), .rs2(rs2),
    .idex_rd(idex_rd), .idex_we(idex_we),
    .exmem_rd(exmem_rd), .exmem_we(exmem_we),
    .memwb_rd(memwb_rd), .memwb_we(memwb_we),
    .branch_taken(branch_taken),
    .imem_address(imem_address), .imem_rdata(imem_rdata),
    .dmem_address(dmem_address), .dmem_wdata(dmem_wdata),
    .dmem_read(dmem_read), .dmem_write(dmem_write),
    .dmem_rdata(dmem_rdata)
  );

endmodule

`default_nettype wire

// File: hw/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import rv32i_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  hazard_if.dp        hz,
  input  ctrl_word    idex_ctrl_word,
  output rv32i_opcode opcode,
  output logic [2:0]  funct3,
  output logic [6:0]  funct7,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  idex_rd,
  output logic        idex_we,
  output logic [4:0]  exmem_rd,
  output logic        exmem_we,
  output logic [4:0]  memwb_rd,
  output logic        memwb_we,
  output logic        branch_taken,
  output logic [31:0] imem_address,
  input  logic [31:0] imem_rdata,
  output logic [31:0] dmem_address,
  output logic [31:0] dmem_wdata,
  output logic        dmem_read,
  output logic        dmem_write,
  input  logic [31:0] dmem_rdata
);

  logic [31:0]       pc;
  logic [31:0]       branch_target;
  logic [31:0]       id_word;
  instruction_decode id_decode;
  logic [31:0]       rs1_data;
  logic [31:0]       rs2_data;
  logic [31:0]       alumux1_out;
  logic [31:0]       alumux2_out;
  logic [31:0]       cmpmux_out;
  logic [31:0]       alu_out;
  logic              br_en;
  logic [31:0]       regfilemux_out;

  ifid_t  ifid_d, ifid_q;
  idex_t  idex_d, idex_q;
  exmem_t exmem_d, exmem_q;
  memwb_t memwb_d, memwb_q;

  function automatic instruction_decode decode(input logic [31:0] w);
    instruction_decode d;
    d.opcode = rv32i_opcode'(w[6:0]);
    d.funct3 = w[14:12];
    d.funct7 = w[31:25];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.rd     = w[11:7];
    d.i_imm  = {{21{w[31]}}, w[30:20]};
    d.s_imm  = {{21{w[31]}}, w[30:25], w[11:7]};
    d.b_imm  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    d.u_imm  = {w[31:12], 12'h000};
    d.j_imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    return d;
  endfunction

  //**************************************************************************
  // IF
  //**************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (hz.load_pc) begin
      pc <= branch_taken ? branch_target : pc + 32'd4;
    end
  end

  assign imem_address = pc;
  assign ifid_d       = '{valid: 1'b1, pc: pc, instr: imem_rdata};

  pipe_register #(.payload_t(ifid_t)) ifid_reg (
    .clk(clk), .rst_n(rst_n), .load(hz.load_ifid), .flush(hz.flush_ifid),
    .d(ifid_d), .q(ifid_q)
  );

  //**************************************************************************
  // ID
  //**************************************************************************

  // an empty slot decodes as a nop
  assign id_word   = ifid_q.valid ? ifid_q.instr : nop_word;
  assign id_decode = decode(id_word);

  assign opcode = id_decode.opcode;
  assign funct3 = id_decode.funct3;
  assign funct7 = id_decode.funct7;
  assign rs1    = id_decode.rs1;
  assign rs2    = id_decode.rs2;

  regfile regfile (
    .clk(clk), .rst_n(rst_n),
    .we(memwb_q.ctrl.load_regfile), .rd(memwb_q.idecode.rd), .wdata(regfilemux_out),
    .rs1(id_decode.rs1), .rs2(id_decode.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign idex_d = '{idecode: id_decode, ctrl: idex_ctrl_word, pc: ifid_q.pc,
                    rs1_data: rs1_data, rs2_data: rs2_data};

  pipe_register #(.payload_t(idex_t)) idex_reg (
    .clk(clk), .rst_n(rst_n), .load(hz.load_idex), .flush(hz.flush_idex),
    .d(idex_d), .q(idex_q)
  );

  //**************************************************************************
  // EX
  //**************************************************************************

  always_comb begin
    case (idex_q.ctrl.alumux1_sel)
      a1_pc_out: alumux1_out = idex_q.pc;
      default:   alumux1_out = idex_q.rs1_data;
    endcase

    case (idex_q.ctrl.alumux2_sel)
      a2_i_imm: alumux2_out = idex_q.idecode.i_imm;
      a2_u_imm: alumux2_out = idex_q.idecode.u_imm;
      a2_b_imm: alumux2_out = idex_q.idecode.b_imm;
      a2_s_imm: alumux2_out = idex_q.idecode.s_imm;
      default:  alumux2_out = idex_q.rs2_data;
    endcase

    case (idex_q.ctrl.cmpmux_sel)
      cmp_i_imm: cmpmux_out = idex_q.idecode.i_imm;
      default:   cmpmux_out = idex_q.rs2_data;
    endcase
  end

  alu alu (
    .aluop(idex_q.ctrl.aluop), .a(alumux1_out), .b(alumux2_out), .f(alu_out),
    .cmpop(idex_q.ctrl.cmpop), .cmp_a(idex_q.rs1_data), .cmp_b(cmpmux_out),
    .br_en(br_en)
  );

  // branch flag as it enters EX/MEM, target taken word aligned
  assign branch_taken  = (idex_q.idecode.opcode == op_br) && br_en;
  assign branch_target = {alu_out[31:2], 2'b00};

  assign exmem_d = '{idecode: idex_q.idecode, ctrl: idex_q.ctrl, alu_out: alu_out,
                     rs2_data: idex_q.rs2_data, br_en: br_en};

  pipe_register #(.payload_t(exmem_t)) exmem_reg (
    .clk(clk), .rst_n(rst_n), .load(hz.load_exmem), .flush(hz.flush_exmem),
    .d(exmem_d), .q(exmem_q)
  );

  //**************************************************************************
  // MEM and WB
  //**************************************************************************

  assign dmem_address = exmem_q.alu_out;
  assign dmem_wdata   = exmem_q.rs2_data;
  assign dmem_read    = exmem_q.ctrl.mem_read;
  assign dmem_write   = exmem_q.ctrl.mem_write;

  assign memwb_d = '{idecode: exmem_q.idecode, ctrl: exmem_q.ctrl,
                     alu_out: exmem_q.alu_out, br_en: exmem_q.br_en, mdr: dmem_rdata};

  pipe_register #(.payload_t(memwb_t)) memwb_reg (
    .clk(clk), .rst_n(rst_n), .load(hz.load_memwb), .flush(hz.flush_memwb),
    .d(memwb_d), .q(memwb_q)
  );

  always_comb begin
    case (memwb_q.ctrl.regfilemux_sel)
      rf_br_en:   regfilemux_out = {31'd0, memwb_q.br_en};
      rf_u_imm:   regfilemux_out = memwb_q.idecode.u_imm;
      rf_mdr_out: regfilemux_out = memwb_q.mdr;
      default:    regfilemux_out = memwb_q.alu_out;
    endcase
  end

  // destinations watched by the hazard logic
  assign idex_rd  = idex_q.idecode.rd;
  assign idex_we  = idex_q.ctrl.load_regfile;
  assign exmem_rd = exmem_q.idecode.rd;
  assign exmem_we = exmem_q.ctrl.load_regfile;
  assign memwb_rd = memwb_q.idecode.rd;
  assign memwb_we = memwb_q.ctrl.load_regfile;

  a_dmem_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write)
  );

endmodule

`default_nettype wire

// File: hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv32i_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  rv32i_opcode opcode,
  input  logic [2:0]  funct3,
  input  logic [6:0]  funct7,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  idex_rd,
  input  logic        idex_we,
  input  logic [4:0]  exmem_rd,
  input  logic        exmem_we,
  input  logic [4:0]  memwb_rd,
  input  logic        memwb_we,
  input  logic        branch_taken,
  output ctrl_word    idex_ctrl_word,
  hazard_if.ctrl      hz
);

  logic uses_rs1;
  logic uses_rs2;
  logic raw;
  logic stall;

  //**************************************************************************
  // control word
  //**************************************************************************

  always_comb begin
    idex_ctrl_word = '0;
    case (opcode)
      op_lui: begin
        idex_ctrl_word.regfilemux_sel = rf_u_imm;
        idex_ctrl_word.load_regfile   = 1'b1;
      end
      op_auipc: begin
        idex_ctrl_word.alumux1_sel  = a1_pc_out;
        idex_ctrl_word.alumux2_sel  = a2_u_imm;
        idex_ctrl_word.load_regfile = 1'b1;
      end
      op_br: begin
        // alu forms the target, comparator decides
        idex_ctrl_word.alumux1_sel = a1_pc_out;
        idex_ctrl_word.alumux2_sel = a2_b_imm;
        idex_ctrl_word.cmpop       = branch_funct3_t'(funct3);
      end
      op_load: begin
        idex_ctrl_word.alumux2_sel    = a2_i_imm;
        idex_ctrl_word.regfilemux_sel = rf_mdr_out;
        idex_ctrl_word.mem_read       = 1'b1;
        idex_ctrl_word.load_regfile   = 1'b1;
      end
      op_store: begin
        idex_ctrl_word.alumux2_sel = a2_s_imm;
        idex_ctrl_word.mem_write   = 1'b1;
      end
      op_imm, op_reg: begin
        idex_ctrl_word.load_regfile = 1'b1;
        idex_ctrl_word.aluop        = alu_ops'(funct3);
        if (opcode == op_imm) begin
          idex_ctrl_word.alumux2_sel = a2_i_imm;
          idex_ctrl_word.cmpmux_sel  = cmp_i_imm;
        end
        case (funct3)
          3'b010: begin
            idex_ctrl_word.cmpop          = blt;
            idex_ctrl_word.regfilemux_sel = rf_br_en;
          end
          3'b011: begin
            idex_ctrl_word.cmpop          = bltu;
            idex_ctrl_word.regfilemux_sel = rf_br_en;
          end
          3'b101: begin
            idex_ctrl_word.aluop = funct7[5] ? alu_sra : alu_srl;
          end
          3'b000: begin
            // only op has sub, addi keeps its immediate bit
            if (opcode == op_reg && funct7[5]) begin
              idex_ctrl_word.aluop = alu_sub;
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  //**************************************************************************
  // hazards
  //**************************************************************************

  assign uses_rs1 = (opcode != op_lui) && (opcode != op_auipc);
  assign uses_rs2 = (opcode == op_br) || (opcode == op_store) || (opcode == op_reg);

  // no forwarding, so wait until the producer sits in writeback
  always_comb begin
    raw = 1'b0;
    if (uses_rs1 && rs1 != 5'd0) begin
      raw = (idex_we && idex_rd == rs1) || (exmem_we && exmem_rd == rs1);
    end
    if (uses_rs2 && rs2 != 5'd0) begin
      raw = raw || (idex_we && idex_rd == rs2) || (exmem_we && exmem_rd == rs2);
    end
  end

  // a taken branch kills the stalled instruction anyway
  assign stall = raw && !branch_taken;

  assign hz.load_pc     = !stall;
  assign hz.load_ifid   = !stall;
  assign hz.flush_ifid  = branch_taken;
  assign hz.load_idex   = 1'b1;
  assign hz.flush_idex  = branch_taken || stall;
  assign hz.load_exmem  = 1'b1;
  assign hz.flush_exmem = 1'b0;
  assign hz.load_memwb  = 1'b1;
  assign hz.flush_memwb = 1'b0;

  // stall never outlasts the two cycles a producer needs to reach writeback
  a_stall_bounded: assert property (
    @(posedge clk) disable iff (!rst_n) (stall && $past(stall)) |=> !stall
  );

  // a pending write in MEM always lands in WB one cycle later
  a_producer_advances: assert property (
    @(posedge clk) disable iff (!rst_n)
    (exmem_we && exmem_rd != 5'd0) |=> (memwb_we && memwb_rd == $past(exmem_rd))
  );

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv32i_pkg::*; (
  input  alu_ops         aluop,
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  output logic [31:0]    f,
  input  branch_funct3_t cmpop,
  input  logic [31:0]    cmp_a,
  input  logic [31:0]    cmp_b,
  output logic           br_en
);

  always_comb begin
    case (aluop)
      alu_add: f = a + b;
      alu_sll: f = a << b[4:0];
      alu_sra: f = $unsigned($signed(a) >>> b[4:0]);
      alu_sub: f = a - b;
      alu_xor: f = a ^ b;
      alu_srl: f = a >> b[4:0];
      alu_or:  f = a | b;
      alu_and: f = a & b;
      default: f = a + b;
    endcase
  end

  // comparator, shared by branches and slt/sltu
  always_comb begin
    case (cmpop)
      beq:     br_en = (cmp_a == cmp_b);
      bne:     br_en = (cmp_a != cmp_b);
      blt:     br_en = ($signed(cmp_a) < $signed(cmp_b));
      bge:     br_en = ($signed(cmp_a) >= $signed(cmp_b));
      bltu:    br_en = (cmp_a < cmp_b);
      bgeu:    br_en = (cmp_a >= cmp_b);
      default: br_en = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        we,
  input  logic [4:0]  rd,
  input  logic [31:0] wdata,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  // x1..x31, x0 has no storage
  logic [31:1][31:0] regs;

  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // same-cycle write is visible to decode
  always_comb begin
    if (rs1 == 5'd0) begin
      rs1_data = '0;
    end else if (we && rd == rs1) begin
      rs1_data = wdata;
    end else begin
      rs1_data = regs[rs1];
    end

    if (rs2 == 5'd0) begin
      rs2_data = '0;
    end else if (we && rd == rs2) begin
      rs2_data = wdata;
    end else begin
      rs2_data = regs[rs2];
    end
  end

  // a write carries a defined destination and value
  a_write_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(we) && (!we || !$isunknown({rd, wdata}))
  );

endmodule

`default_nettype wire

// File: hw/pipe_register.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_register #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  localparam payload_t bubble = '0;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      q <= bubble;
    end else if (load) begin
      q <= d;
    end
  end

  // stage controls come from the hazard logic and are always defined
  a_controls_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({load, flush})
  );

endmodule

`default_nettype wire

// File: hw/hazard_if.sv
`timescale 1ns/1ps
`default_nettype none

// per-stage load and flush levels, flush wins over load
interface hazard_if;

  logic load_pc;
  logic load_ifid;
  logic flush_ifid;
  logic load_idex;
  logic flush_idex;
  logic load_exmem;
  logic flush_exmem;
  logic load_memwb;
  logic flush_memwb;

  modport ctrl (
    output load_pc, load_ifid, flush_ifid, load_idex, flush_idex,
           load_exmem, flush_exmem, load_memwb, flush_memwb
  );

  modport dp (
    input load_pc, load_ifid, flush_ifid, load_idex, flush_idex,
          load_exmem, flush_exmem, load_memwb, flush_memwb
  );

endinterface

`default_nettype wire

// File: hw/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  localparam logic [31:0] reset_pc = 32'h0000_0000;
  // addi x0, x0, 0
  localparam logic [31:0] nop_word = 32'h0000_0013;

  //**************************************************************************
  // encodings
  //**************************************************************************

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  // matches funct3 except sra and sub, which take the slt slots
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_ops;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  typedef enum logic {
    a1_rs1_out = 1'b0,
    a1_pc_out  = 1'b1
  } alumux1_sel_t;

  typedef enum logic [2:0] {
    a2_rs2_out = 3'd0,
    a2_i_imm   = 3'd1,
    a2_u_imm   = 3'd2,
    a2_b_imm   = 3'd3,
    a2_s_imm   = 3'd4
  } alumux2_sel_t;

  typedef enum logic {
    cmp_rs2_out = 1'b0,
    cmp_i_imm   = 1'b1
  } cmpmux_sel_t;

  typedef enum logic [1:0] {
    rf_alu_out = 2'd0,
    rf_br_en   = 2'd1,
    rf_u_imm   = 2'd2,
    rf_mdr_out = 2'd3
  } regfilemux_sel_t;

  //**************************************************************************
  // decoded instruction and control word
  //**************************************************************************

  typedef struct packed {
    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;
  } instruction_decode;

  // all zero is a bubble: no register or memory write
  typedef struct packed {
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
    regfilemux_sel_t regfilemux_sel;
    alu_ops          aluop;
    branch_funct3_t  cmpop;
    logic            load_regfile;
    logic            mem_read;
    logic            mem_write;
  } ctrl_word;

  //**************************************************************************
  // stage payloads
  //**************************************************************************

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } ifid_t;

  typedef struct packed {
    instruction_decode idecode;
    ctrl_word          ctrl;
    logic [31:0]       pc;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
  } idex_t;

  typedef struct packed {
    instruction_decode idecode;
    ctrl_word          ctrl;
    logic [31:0]       alu_out;
    logic [31:0]       rs2_data;
    logic              br_en;
  } exmem_t;

  typedef struct packed {
    instruction_decode idecode;
    ctrl_word          ctrl;
    logic [31:0]       alu_out;
    logic              br_en;
    logic [31:0]       mdr;
  } memwb_t;

endpackage

`default_nettype wire
